// File: hdl/noc_router_pkg.sv
package noc_router_pkg;

  ////////////////////////////////////////////////////////////
  // ports and direction codes
  ////////////////////////////////////////////////////////////

  localparam int num_ports = 5;

  typedef logic [2:0] port_idx_t;
  typedef logic [num_ports-1:0] dir_t;
  typedef logic [num_ports-1:0] port_vec_t;

  localparam port_idx_t port_north = 3'd0;
  localparam port_idx_t port_south = 3'd1;
  localparam port_idx_t port_west  = 3'd2;
  localparam port_idx_t port_east  = 3'd3;
  localparam port_idx_t port_local = 3'd4;

  // one-hot codes where bit p selects output port p
  localparam dir_t dir_north = dir_t'(1) << port_north;
  localparam dir_t dir_south = dir_t'(1) << port_south;
  localparam dir_t dir_west  = dir_t'(1) << port_west;
  localparam dir_t dir_east  = dir_t'(1) << port_east;
  localparam dir_t dir_local = dir_t'(1) << port_local;

  ////////////////////////////////////////////////////////////
  // flit layout
  ////////////////////////////////////////////////////////////

  typedef logic [2:0] coord_t;

  // y grows toward the south edge of the mesh
  typedef struct packed {
    coord_t x;
    coord_t y;
  } xy_t;

  typedef logic [4:0] msg_t;

  localparam int data_width = 64;
  localparam int reserved_width =
    data_width - 2 * $bits(xy_t) - $bits(msg_t) - $bits(dir_t);

  typedef struct packed {
    logic head;
    logic tail;
  } preamble_t;

  typedef struct packed {
    preamble_t                 preamble;
    xy_t                       source;
    xy_t                       destination;
    msg_t                      message;
    logic [reserved_width-1:0] reserved;
    dir_t                      routing;
  } header_t;

  typedef struct packed {
    preamble_t               preamble;
    logic [data_width-1:0]   data;
  } flit_t;

  typedef flit_t [num_ports-1:0] flit_vec_t;

  // input buffering
  localparam int queue_depth = 4;
  localparam int queue_addr_width = $clog2(queue_depth);

  typedef enum logic [1:0] {
    reserve_port,
    head_flit,
    payload_flits
  } worm_state_t;

endpackage

// File: hdl/flit_queue.sv
`timescale 1ns/10ps

module flit_queue (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  wr_i,
  input  logic                  rd_i,
  input  noc_router_pkg::flit_t data_i,
  output noc_router_pkg::flit_t data_o,
  output logic                  empty_o,
  output logic                  full_o
);

  import noc_router_pkg::*;

  flit_t                       mem [queue_depth];
  logic [queue_addr_width-1:0] wr_ptr;
  logic [queue_addr_width-1:0] rd_ptr;
  logic [queue_addr_width:0]   count;
  logic                        do_wr;
  logic                        do_rd;

  function automatic logic [queue_addr_width-1:0] next_ptr(
    input logic [queue_addr_width-1:0] ptr
  );
    return (ptr == queue_addr_width'(queue_depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // writes to a full queue and reads from an empty one are dropped
  assign do_wr = wr_i & ~full_o;
  assign do_rd = rd_i & ~empty_o;

  assign empty_o = (count == '0);
  assign full_o  = (count == (queue_addr_width + 1)'(queue_depth));
  assign data_o  = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= data_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_rd) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: hdl/input_port.sv
`timescale 1ns/10ps

module input_port (
  input  logic                  clk,
  input  logic                  rst,
  input  noc_router_pkg::flit_t data_i,
  input  logic                  data_void_i,
  input  logic                  rd_i,
  output logic                  stop_o,
  output noc_router_pkg::flit_t head_o,
  output logic                  head_valid_o,
  output noc_router_pkg::dir_t  request_o
);

  import noc_router_pkg::*;

  logic    wr;
  logic    full;
  logic    empty;
  logic    head_at_front;
  logic    tail_read;
  header_t head_hdr;
  dir_t    held_route;

  assign wr = ~data_void_i;

  flit_queue i_flit_queue (
    .clk     (clk),
    .rst     (rst),
    .wr_i    (wr),
    .rd_i    (rd_i),
    .data_i  (data_i),
    .data_o  (head_o),
    .empty_o (empty),
    .full_o  (full)
  );

  // back-pressure toward the upstream sender
  assign stop_o       = full;
  assign head_valid_o = ~empty;

  assign head_hdr      = header_t'(head_o);
  assign head_at_front = ~empty & head_o.preamble.head;
  assign tail_read     = rd_i & ~empty & head_o.preamble.tail;

  ////////////////////////////////////////////////////////////
  // worm tracking
  ////////////////////////////////////////////////////////////

  // keeps the request alive between head and tail
  always_ff @(posedge clk) begin
    if (rst) begin
      held_route <= '0;
    end else if (tail_read) begin
      held_route <= '0;
    end else if (head_at_front) begin
      held_route <= head_hdr.routing;
    end
  end

  assign request_o = head_at_front ? head_hdr.routing : held_route;

endmodule

// File: hdl/lookahead_route.sv
`timescale 1ns/10ps

module lookahead_route (
  input  noc_router_pkg::xy_t  position_i,
  input  noc_router_pkg::dir_t out_dir_i,
  input  noc_router_pkg::xy_t  destination_i,
  output noc_router_pkg::dir_t next_route_o
);

  import noc_router_pkg::*;

  xy_t neighbor;

  // tile reached through this output
  always_comb begin
    neighbor = position_i;
    case (out_dir_i)
      dir_north: neighbor.y = position_i.y - 1'b1;
      dir_south: neighbor.y = position_i.y + 1'b1;
      dir_west:  neighbor.x = position_i.x - 1'b1;
      dir_east:  neighbor.x = position_i.x + 1'b1;
      default:   neighbor = position_i;
    endcase
  end

  // xy order at the neighbor with x first and y second
  always_comb begin
    if (destination_i.x > neighbor.x) begin
      next_route_o = dir_east;
    end else if (destination_i.x < neighbor.x) begin
      next_route_o = dir_west;
    end else if (destination_i.y > neighbor.y) begin
      next_route_o = dir_south;
    end else if (destination_i.y < neighbor.y) begin
      next_route_o = dir_north;
    end else begin
      next_route_o = dir_local;
    end
  end

endmodule

// File: hdl/output_port.sv
`timescale 1ns/10ps

module output_port #(
  parameter noc_router_pkg::port_idx_t out_port = noc_router_pkg::port_north
) (
  input  logic                      clk,
  input  logic                      rst,
  input  noc_router_pkg::xy_t       position_i,
  input  noc_router_pkg::flit_vec_t heads_i,
  input  noc_router_pkg::port_vec_t head_valid_i,
  input  noc_router_pkg::port_vec_t requests_i,
  input  logic                      stop_i,
  output noc_router_pkg::port_vec_t rd_o,
  output noc_router_pkg::flit_t     data_o,
  output logic                      data_void_o
);

  import noc_router_pkg::*;

  localparam dir_t out_dir = dir_t'(1) << out_port;

  worm_state_t state_q;
  worm_state_t state_d;
  port_idx_t   rr_ptr_q;
  port_idx_t   grant_q;
  port_idx_t   winner;
  logic        found;
  logic        take_grant;
  flit_t       sel_flit;
  logic        sel_valid;
  logic        forward;
  header_t     sel_hdr;
  header_t     out_hdr;
  flit_t       out_flit;
  dir_t        next_route;

  ////////////////////////////////////////////////////////////
  // round-robin arbiter
  ////////////////////////////////////////////////////////////

  // rr_ptr_q holds the input with the highest priority
  always_comb begin
    int cand;
    found  = 1'b0;
    winner = rr_ptr_q;
    for (int k = 0; k < num_ports; k++) begin
      cand = int'(rr_ptr_q) + k;
      if (cand >= num_ports) begin
        cand = cand - num_ports;
      end
      if (!found && requests_i[cand]) begin
        found  = 1'b1;
        winner = port_idx_t'(cand);
      end
    end
  end

  assign take_grant = (state_q == reserve_port) & found & ~stop_i;

  ////////////////////////////////////////////////////////////
  // crossbar and head rewrite
  ////////////////////////////////////////////////////////////

  assign sel_flit  = heads_i[grant_q];
  assign sel_valid = head_valid_i[grant_q];
  assign forward   = (state_q != reserve_port) & sel_valid & ~stop_i;

  assign rd_o = forward ? (port_vec_t'(1) << grant_q) : '0;

  assign sel_hdr = header_t'(sel_flit);

  lookahead_route i_lookahead_route (
    .position_i    (position_i),
    .out_dir_i     (out_dir),
    .destination_i (sel_hdr.destination),
    .next_route_o  (next_route)
  );

  // only the head carries routing, payload passes untouched
  always_comb begin
    out_hdr = sel_hdr;
    if (state_q == head_flit) begin
      out_hdr.routing = next_route;
    end
    out_flit = flit_t'(out_hdr);
  end

  ////////////////////////////////////////////////////////////
  // worm FSM
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      reserve_port: begin
        if (take_grant) begin
          state_d = head_flit;
        end
      end
      head_flit: begin
        if (forward) begin
          // single-flit worms go straight back
          state_d = sel_flit.preamble.tail ? reserve_port : payload_flits;
        end
      end
      payload_flits: begin
        if (forward && sel_flit.preamble.tail) begin
          state_d = reserve_port;
        end
      end
      default: state_d = reserve_port;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q     <= reserve_port;
      grant_q     <= port_north;
      rr_ptr_q    <= port_north;
      data_void_o <= 1'b1;
    end else begin
      state_q <= state_d;
      if (take_grant) begin
        grant_q  <= winner;
        rr_ptr_q <= (winner == port_local) ? port_north : winner + 1'b1;
      end
      // output holds while the receiver stops us
      if (!stop_i) begin
        data_void_o <= ~forward;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (forward) begin
      data_o <= out_flit;
    end
  end

endmodule

// File: hdl/mesh_router.sv
`timescale 1ns/10ps

module mesh_router (
  input  logic                      clk,
  input  logic                      rst,
  input  noc_router_pkg::xy_t       position_i,
  input  noc_router_pkg::flit_vec_t data_i,
  input  noc_router_pkg::port_vec_t data_void_i,
  output wire noc_router_pkg::port_vec_t stop_o,
  output wire noc_router_pkg::flit_vec_t data_o,
  output wire noc_router_pkg::port_vec_t data_void_o,
  input  noc_router_pkg::port_vec_t stop_i
);

  import noc_router_pkg::*;

  wire flit_vec_t                  heads;
  wire port_vec_t                  head_valid;
  // requests[i] is indexed by output, req_to_out[p] by input
  wire dir_t      [num_ports-1:0]  requests;
  wire port_vec_t [num_ports-1:0]  req_to_out;
  // rd_from_out[p] is indexed by input, rd_to_in[i] by output
  wire port_vec_t [num_ports-1:0]  rd_from_out;
  wire port_vec_t [num_ports-1:0]  rd_to_in;
  wire port_vec_t                  rd_any;

  for (genvar g_i = 0; g_i < num_ports; g_i++) begin : gen_port
    localparam port_idx_t this_port = port_idx_t'(g_i);

    for (genvar g_j = 0; g_j < num_ports; g_j++) begin : gen_transpose
      assign req_to_out[g_i][g_j] = requests[g_j][g_i];
      assign rd_to_in[g_i][g_j]   = rd_from_out[g_j][g_i];
    end

    // any output may pop this input
    assign rd_any[g_i] = |rd_to_in[g_i];

    input_port i_input_port (
      .clk          (clk),
      .rst          (rst),
      .data_i       (data_i[g_i]),
      .data_void_i  (data_void_i[g_i]),
      .rd_i         (rd_any[g_i]),
      .stop_o       (stop_o[g_i]),
      .head_o       (heads[g_i]),
      .head_valid_o (head_valid[g_i]),
      .request_o    (requests[g_i])
    );

    output_port #(
      .out_port (this_port)
    ) i_output_port (
      .clk          (clk),
      .rst          (rst),
      .position_i   (position_i),
      .heads_i      (heads),
      .head_valid_i (head_valid),
      .requests_i   (req_to_out[g_i]),
      .stop_i       (stop_i[g_i]),
      .rd_o         (rd_from_out[g_i]),
      .data_o       (data_o[g_i]),
      .data_void_o  (data_void_o[g_i])
    );
  end

endmodule

// File: sim/router_checker.sv
`timescale 1ns/10ps

module router_checker (
  input  logic                      clk,
  input  logic                      rst,
  input  noc_router_pkg::xy_t       position_i,
  input  noc_router_pkg::flit_vec_t in_data_i,
  input  noc_router_pkg::port_vec_t in_void_i,
  input  noc_router_pkg::port_vec_t in_stop_i,
  input  noc_router_pkg::flit_vec_t out_data_i,
  input  noc_router_pkg::port_vec_t out_void_i,
  input  noc_router_pkg::port_vec_t out_stop_i,
  input  logic                      end_check_i,
  output int                        mismatch_count_o,
  output int                        failure_count_o,
  output int                        delivered_o
);

  import noc_router_pkg::*;

  // one queue of expected flits per input and output pair
  flit_t     exp_q [num_ports*num_ports][$];
  int        in_route  [num_ports];
  int        out_src   [num_ports];
  int        reg_src   [num_ports];
  int        occupancy [num_ports];
  port_vec_t out_busy;
  port_vec_t accept_q;
  port_vec_t stop_q;
  port_vec_t void_q;
  flit_vec_t data_q;
  logic      after_reset;

  function automatic int xy_port(int cx, int cy, int dx, int dy);
    if (dx != cx) begin
      return (dx > cx) ? int'(port_east) : int'(port_west);
    end
    if (dy != cy) begin
      return (dy > cy) ? int'(port_south) : int'(port_north);
    end
    return int'(port_local);
  endfunction

  // routing a head must carry after output p as decided at the tile beyond p
  function automatic flit_t rewrite_head(flit_t f, int p, xy_t pos);
    header_t h;
    int      nx;
    int      ny;
    h  = header_t'(f);
    nx = int'(pos.x) + ((p == int'(port_east)) ? 1 : 0) - ((p == int'(port_west)) ? 1 : 0);
    ny = int'(pos.y) + ((p == int'(port_south)) ? 1 : 0) - ((p == int'(port_north)) ? 1 : 0);
    h.routing = dir_t'(1) << xy_port(nx, ny, int'(h.destination.x), int'(h.destination.y));
    return flit_t'(h);
  endfunction

  function automatic int onehot_index(dir_t d);
    int idx;
    idx = -1;
    for (int k = 0; k < num_ports; k++) begin
      if (d == (dir_t'(1) << k)) begin
        idx = k;
      end
    end
    return idx;
  endfunction

  always @(posedge clk) begin
    flit_t   f;
    header_t hdr;
    int      src;
    int      k;
    int      reads [num_ports];
    if (rst) begin
      out_busy         = '0;
      accept_q         = '0;
      after_reset      = 1'b1;
      mismatch_count_o = 0;
      failure_count_o  = 0;
      delivered_o      = 0;
      for (int i = 0; i < num_ports; i++) begin
        occupancy[i] = 0;
        in_route[i]  = 0;
        out_src[i]   = 0;
        reg_src[i]   = 0;
      end
    end else begin
      if (after_reset && out_void_i !== '1) begin
        $display("mismatch data_void_o after reset %h expected %h", out_void_i, 5'h1f);
        mismatch_count_o++;
      end
      if (after_reset && in_stop_i !== '0) begin
        $display("mismatch stop_o after reset %h expected %h", in_stop_i, 5'h00);
        mismatch_count_o++;
      end
      after_reset = 1'b0;

      ////////////////////////////////////////////////////////////
      // output hold and queue reads seen one edge late
      ////////////////////////////////////////////////////////////
      for (int i = 0; i < num_ports; i++) begin
        reads[i] = 0;
      end
      for (int p = 0; p < num_ports; p++) begin
        if (!stop_q[p] && !out_void_i[p]) begin
          hdr = header_t'(out_data_i[p]);
          if (out_data_i[p].preamble.head) begin
            reg_src[p] = int'(hdr.message);
          end
          if (reg_src[p] < num_ports) begin
            reads[reg_src[p]]++;
          end
        end
        if (stop_q[p] && (out_void_i[p] !== void_q[p] ||
                          (!void_q[p] && out_data_i[p] !== data_q[p]))) begin
          $display("mismatch data_o[%0d] under stop_i %h was %h (void %h was %h)",
                   p, out_data_i[p], data_q[p], out_void_i[p], void_q[p]);
          mismatch_count_o++;
        end
      end

      ////////////////////////////////////////////////////////////
      // queue fill and expected traffic on the input side
      ////////////////////////////////////////////////////////////
      for (int i = 0; i < num_ports; i++) begin
        occupancy[i] = occupancy[i] + int'(accept_q[i]) - reads[i];
        if (occupancy[i] < 0 || occupancy[i] > queue_depth) begin
          $display("input %0d queue overflowed or underflowed, model holds %0d flits",
                   i, occupancy[i]);
          failure_count_o++;
        end
        if (in_stop_i[i] !== (occupancy[i] == queue_depth)) begin
          $display("mismatch stop_o[%0d] %h expected %h",
                   i, in_stop_i[i], occupancy[i] == queue_depth);
          mismatch_count_o++;
        end
        accept_q[i] = !in_void_i[i] && !in_stop_i[i];
        if (accept_q[i]) begin
          f   = in_data_i[i];
          hdr = header_t'(f);
          if (f.preamble.head) begin
            in_route[i] = onehot_index(hdr.routing);
            f = rewrite_head(f, in_route[i], position_i);
          end
          exp_q[i*num_ports + in_route[i]].push_back(f);
        end
      end

      // a delivered worm locks its output from head to tail
      for (int p = 0; p < num_ports; p++) begin
        if (!out_void_i[p] && !out_stop_i[p]) begin
          f   = out_data_i[p];
          hdr = header_t'(f);
          delivered_o++;
          src = out_busy[p] ? out_src[p] : -1;
          if (!out_busy[p] && f.preamble.head) begin
            src = int'(hdr.message);
          end
          k = src * num_ports + p;
          if (src < 0 || src >= num_ports || exp_q[k].size() == 0) begin
            $display("mismatch data_o[%0d] %h with no flit expected on this output", p, f);
            mismatch_count_o++;
          end else begin
            if (f !== exp_q[k][0]) begin
              $display("mismatch data_o[%0d] %h expected %h", p, f, exp_q[k][0]);
              mismatch_count_o++;
            end
            void'(exp_q[k].pop_front());
            out_src[p]  = src;
            out_busy[p] = !f.preamble.tail;
          end
        end
      end

      if (end_check_i) begin
        for (int q = 0; q < num_ports*num_ports; q++) begin
          if (exp_q[q].size() != 0) begin
            $display("worm from input %0d to output %0d is still missing %0d flits",
                     q / num_ports, q % num_ports, exp_q[q].size());
            failure_count_o++;
          end
        end
      end
    end
    stop_q = out_stop_i;
    void_q = out_void_i;
    data_q = out_data_i;
  end

endmodule

// File: sim/tb_mesh_router.sv
`timescale 1ns/10ps

module tb_mesh_router;

  import noc_router_pkg::*;

  localparam int tile_x          = 3;
  localparam int tile_y          = 3;
  localparam int worms_per_input = 30;
  localparam int cycles_per_flit = 40;

  logic      clk;
  logic      rst;
  xy_t       position;
  flit_vec_t data_in;
  port_vec_t data_void_in;
  port_vec_t stop_out;
  flit_vec_t data_out;
  port_vec_t data_void_out;
  port_vec_t stop_in;
  logic      end_check;
  logic      timed_out;

  integer seed;
  int     worm_len   [num_ports][worms_per_input];
  int     worm_idx   [num_ports];
  int     flit_idx   [num_ports];
  int     seq_num    [num_ports];
  xy_t    worm_dest  [num_ports];
  dir_t   worm_route [num_ports];
  int     total_flits;
  int     limit;
  int     cycles;
  int     mismatches;
  int     failures;
  int     delivered;

  mesh_router i_mesh_router (
    .clk         (clk),
    .rst         (rst),
    .position_i  (position),
    .data_i      (data_in),
    .data_void_i (data_void_in),
    .stop_o      (stop_out),
    .data_o      (data_out),
    .data_void_o (data_void_out),
    .stop_i      (stop_in)
  );

  router_checker i_router_checker (
    .clk              (clk),
    .rst              (rst),
    .position_i       (position),
    .in_data_i        (data_in),
    .in_void_i        (data_void_in),
    .in_stop_i        (stop_out),
    .out_data_i       (data_out),
    .out_void_i       (data_void_out),
    .out_stop_i       (stop_in),
    .end_check_i      (end_check),
    .mismatch_count_o (mismatches),
    .failure_count_o  (failures),
    .delivered_o      (delivered)
  );

  // output this tile picks for a destination with x first and then y
  function automatic dir_t tile_route(xy_t dest);
    int dx;
    int dy;
    dx = int'(dest.x) - tile_x;
    dy = int'(dest.y) - tile_y;
    if (dx != 0) begin
      return (dx > 0) ? dir_east : dir_west;
    end
    if (dy != 0) begin
      return (dy > 0) ? dir_south : dir_north;
    end
    return dir_local;
  endfunction

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // worm stimulus and back-pressure
  ////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    flit_t   f;
    header_t h;
    logic    last;
    if (rst) begin
      data_void_in <= '1;
      stop_in      <= '0;
    end else begin
      for (int p = 0; p < num_ports; p++) begin
        stop_in[p] <= (($random(seed) & 3) == 0);
      end
      for (int i = 0; i < num_ports; i++) begin
        // a pending flit stays on the link until stop_o lets it through
        if (data_void_in[i] || !stop_out[i]) begin
          if (worm_idx[i] < worms_per_input && ($random(seed) & 3) != 0) begin
            if (flit_idx[i] == 0) begin
              // reroll until the worm does not turn back to its own input
              do begin
                worm_dest[i].x = coord_t'($random(seed));
                worm_dest[i].y = coord_t'($random(seed));
                worm_route[i]  = tile_route(worm_dest[i]);
              end while (worm_route[i][i]);
            end
            last = (flit_idx[i] == worm_len[i][worm_idx[i]] - 1);
            if (flit_idx[i] == 0) begin
              h.preamble.head   = 1'b1;
              h.preamble.tail   = last;
              h.source          = position;
              h.destination     = worm_dest[i];
              h.message         = msg_t'(i);
              h.reserved        = reserved_width'({$random(seed), $random(seed)});
              h.reserved[15:0]  = 16'(seq_num[i]);
              h.routing         = worm_route[i];
              f = flit_t'(h);
            end else begin
              f.preamble.head = 1'b0;
              f.preamble.tail = last;
              f.data          = {$random(seed), $random(seed)};
              f.data[63:61]   = 3'(i);
              f.data[60:45]   = 16'(seq_num[i]);
            end
            data_in[i]      <= f;
            data_void_in[i] <= 1'b0;
            seq_num[i]++;
            if (last) begin
              worm_idx[i]++;
              flit_idx[i] = 0;
            end else begin
              flit_idx[i]++;
            end
          end else begin
            data_void_in[i] <= 1'b1;
          end
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // run control and closing report
  ////////////////////////////////////////////////////////////

  initial begin
    seed         = 32'h26df;
    rst          = 1'b1;
    data_in      = '0;
    data_void_in = '1;
    stop_in      = '0;
    end_check    = 1'b0;
    position.x   = coord_t'(tile_x);
    position.y   = coord_t'(tile_y);
    total_flits  = 0;
    for (int i = 0; i < num_ports; i++) begin
      worm_idx[i] = 0;
      flit_idx[i] = 0;
      seq_num[i]  = 0;
      for (int w = 0; w < worms_per_input; w++) begin
        worm_len[i][w] = 1 + ($random(seed) & 3);
        total_flits    = total_flits + worm_len[i][w];
      end
    end
    limit = total_flits * cycles_per_flit;

    repeat (3) @(posedge clk);
    rst <= 1'b0;

    cycles = 0;
    while (delivered < total_flits && cycles < limit) begin
      @(negedge clk);
      cycles++;
    end
    timed_out = (delivered < total_flits);
    if (timed_out) begin
      $display("timeout after %0d cycles, only %0d of %0d flits were delivered",
               cycles, delivered, total_flits);
    end

    @(posedge clk);
    end_check <= 1'b1;
    @(posedge clk);
    end_check <= 1'b0;
    @(negedge clk);

    $display("errors: %0d mismatches, %0d other failures",
             mismatches, failures + int'(timed_out));
    if (timed_out || mismatches != 0 || failures != 0) begin
      $display("Finished with errors");
    end else begin
      $display("Finished with no errors");
    end
    $finish;
  end

endmodule

// File: mesh_router.f
hdl/noc_router_pkg.sv
hdl/flit_queue.sv
hdl/input_port.sv
hdl/lookahead_route.sv
hdl/output_port.sv
hdl/mesh_router.sv
sim/router_checker.sv
sim/tb_mesh_router.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the mesh router testbench with Verilator and runs it
set -u
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing -Wno-fatal -f mesh_router.f \
  --top-module tb_mesh_router --Mdir "$build_dir" -o tb_mesh_router
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$build_dir/tb_mesh_router" > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -q "Finished with no errors" "$log_file"; then
  exit 0
fi
exit 1
